// ==== Makefile ====
# Verilator simulation of the entropy generator testbench

VERILATOR ?= verilator
TOP       ?= entropy_gen_tb
FILELIST  ?= entropy_gen.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# Build, run, then decide on the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/entropy_gen_props.sv ====
/*
 * Entropy FSM properties
 * EDN request hold, one-cycle error report, valid preceded by early
 */
`timescale 1ns/100ps

module entropy_gen_props (
  input logic clk_i,
  input logic rst_ni,
  input logic entropy_req_i,
  input logic entropy_ack_i,
  input logic err_valid_i,
  input logic rand_valid_i,
  input logic rand_early_i
);

  // Request without ack must still be up on the next edge
  req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    entropy_req_i && !entropy_ack_i |=> entropy_req_i)
    else $error("EDN request dropped before it was acknowledged");

  // Error report is a single-cycle pulse
  err_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    err_valid_i |=> !err_valid_i)
    else $error("Error report lasted more than one cycle");

  // Early pulse comes one cycle ahead of valid
  early_first: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(rand_valid_i) |-> $past(rand_early_i))
    else $error("Valid rose without an early pulse");

endmodule

bind entropy_fsm entropy_gen_props props0 (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .entropy_req_i (entropy_req_o),
  .entropy_ack_i (entropy_ack_i),
  .err_valid_i   (err_o.valid),
  .rand_valid_i  (rand_valid_o),
  .rand_early_i  (rand_early_o)
);

// ==== bench/entropy_gen_tb.sv ====
/*
 * Entropy generator testbench
 * Dummy valid, SW and EDN reseeding, consume and update sequencing,
 * wait-timer and mode errors, checked against a lane model
 */
`timescale 1ns/100ps

module entropy_gen_tb import entropy_pkg::*; ();

  localparam int NumLanes      = 4;
  localparam int DataW         = NumLanes * LaneW;
  localparam int Period        = 40;
  localparam int NumTests      = 6;
  localparam int CyclesPerTest = 3000;
  localparam int WaitLimit     = 200;
  localparam int WordsPerTest  = NumLanes + 1;

  logic                  clk;
  logic                  rst_n;
  logic                  entropy_req;
  logic                  entropy_ack;
  logic [LaneW-1:0]      entropy_data;
  logic                  rand_valid;
  logic                  rand_early;
  logic [DataW-1:0]      rand_data;
  logic                  rand_update;
  logic                  rand_consumed;
  entropy_mode_e         mode;
  logic                  ready;
  logic                  seed_update;
  logic [LaneW-1:0]      seed_data;
  logic                  refresh;
  logic [PrescalerW-1:0] prescaler;
  logic [TimerW-1:0]     limit;
  err_t                  err;
  logic                  err_processed;

  logic [DataW-1:0] patterns [0:3*WordsPerTest-1];
  logic [LaneW-1:0] model_lanes [NumLanes];
  logic [31:0]      lfsr_q;
  int               checks;
  int               errors;

  tb_clock #(.Period(Period)) u_clock (.clk_o(clk));

  entropy_gen #(.NumLanes(NumLanes)) dut0 (
    .clk_i                  (clk),
    .rst_ni                 (rst_n),
    .entropy_req_o          (entropy_req),
    .entropy_ack_i          (entropy_ack),
    .entropy_data_i         (entropy_data),
    .rand_valid_o           (rand_valid),
    .rand_early_o           (rand_early),
    .rand_data_o            (rand_data),
    .rand_update_i          (rand_update),
    .rand_consumed_i        (rand_consumed),
    .mode_i                 (mode),
    .entropy_ready_i        (ready),
    .seed_update_i          (seed_update),
    .seed_data_i            (seed_data),
    .entropy_refresh_req_i  (refresh),
    .wait_timer_prescaler_i (prescaler),
    .wait_timer_limit_i     (limit),
    .err_o                  (err),
    .err_processed_i        (err_processed)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Model of lanes and permutation
  ////////////////////////////////////////////////////////////////////////////

  // Taps 32 22 2 1 shifting left with feedback into bit 0
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [DataW-1:0] permute_word(input logic [DataW-1:0] w);
    logic [DataW-1:0] res;
    for (int i = 0; i < DataW; i++) begin
      res[i] = w[(i * PermStride) % DataW];
    end
    return res;
  endfunction

  function automatic logic [LaneW-1:0] seed_word(input int t, input int l);
    return patterns[t*WordsPerTest + l][LaneW-1:0];
  endfunction

  // Lanes as the DUT holds them right after the seed writes
  task automatic load_model(input int t);
    logic [LaneW-1:0] w;
    for (int l = 0; l < NumLanes; l++) begin
      w = seed_word(t, l);
      model_lanes[l] = (w == '0) ? LaneFix : w;
    end
  endtask

  // Word captured on a data update while the lanes step on the same edge
  task automatic predict_next(output logic [DataW-1:0] exp);
    logic [DataW-1:0] cat;
    for (int l = 0; l < NumLanes; l++) begin
      cat[l*LaneW +: LaneW] = model_lanes[l];
      model_lanes[l] = lfsr_next(model_lanes[l]);
    end
    exp = permute_word(cat);
  endtask

  // One LFSR step per random bit
  task automatic draw_bits(input int n, output int value);
    value = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      value = value * 2 + int'(lfsr_q[0]);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequencing and checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    ready = 1'b0;
    repeat (5) next_cycle();
    rst_n = 1'b1;
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_word(input logic [DataW-1:0] exp, input string what);
    checks++;
    if (rand_data !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, rand_data, exp);
    end
  endtask

  task automatic check_err(input err_code_e code, input string what);
    checks++;
    if (err.code !== code || err.info !== '0) begin
      errors++;
      $display("Error at %0t ns: %s shows code %0d info %h, expected code %0d info 0",
               $time, what, err.code, err.info, code);
    end
  endtask

  task automatic wait_valid(input logic level, input string what);
    int n;
    n = 0;
    while (rand_valid !== level && n < WaitLimit) begin
      next_cycle();
      n++;
    end
    if (rand_valid !== level) begin
      errors++;
      $display("Gave up at %0t ns waiting for %s", $time, what);
    end
  endtask

  task automatic wait_err(input string what);
    int n;
    n = 0;
    while (err.valid !== 1'b1 && n < WaitLimit) begin
      next_cycle();
      n++;
    end
    if (err.valid !== 1'b1) begin
      errors++;
      $display("Gave up at %0t ns waiting for the %s report", $time, what);
    end
  endtask

  // Ready rising in the reset state drops valid on the next edge
  task automatic raise_ready(input entropy_mode_e m);
    mode  = m;
    ready = 1'b1;
    next_cycle();
    check_bit(rand_valid, 1'b0, "valid after ready");
  endtask

  // One strobe per lane with an idle cycle between
  task automatic sw_reseed(input int t);
    for (int l = 0; l < NumLanes; l++) begin
      seed_data = seed_word(t, l);
      seed_update = 1'b1;
      next_cycle();
      seed_update = 1'b0;
      next_cycle();
    end
  endtask

  // Answer each request after a random 0 to 7 cycle delay
  task automatic edn_reseed(input int t);
    int n;
    int delay;
    for (int l = 0; l < NumLanes; l++) begin
      n = 0;
      while (entropy_req !== 1'b1 && n < WaitLimit) begin
        next_cycle();
        n++;
      end
      if (entropy_req !== 1'b1) begin
        errors++;
        $display("Gave up at %0t ns waiting for the EDN request", $time);
      end
      draw_bits(3, delay);
      repeat (delay) next_cycle();
      entropy_data = seed_word(t, l);
      entropy_ack = 1'b1;
      next_cycle();
      entropy_ack = 1'b0;
    end
  endtask

  // Checks the seeded word and aligns the model with the done edge
  task automatic finish_reseed(input int t, input string what);
    logic [DataW-1:0] exp;
    wait_valid(1'b0, "valid to drop at reseed end");
    wait_valid(1'b1, "valid after reseed");
    check_word(patterns[t*WordsPerTest + NumLanes], what);
    load_model(t);
    predict_next(exp);
  endtask

  task automatic consume_word();
    logic [DataW-1:0] exp;
    rand_consumed = 1'b1;
    next_cycle();
    rand_consumed = 1'b0;
    predict_next(exp);
    check_word(exp, "word after consume");
    check_bit(rand_valid, 1'b0, "valid first cycle after consume");
    next_cycle();
    check_bit(rand_valid, 1'b0, "valid second cycle after consume");
    next_cycle();
    check_bit(rand_valid, 1'b1, "valid third cycle after consume");
  endtask

  task automatic update_word();
    logic [DataW-1:0] exp;
    rand_update = 1'b1;
    next_cycle();
    rand_update = 1'b0;
    predict_next(exp);
    check_word(exp, "word after update");
    check_bit(rand_valid, 1'b1, "valid after update");
  endtask

  task automatic clear_error();
    ready = 1'b0;
    err_processed = 1'b1;
    next_cycle();
    err_processed = 1'b0;
    check_bit(rand_early, 1'b1, "early back in dummy state");
    check_bit(rand_valid, 1'b1, "valid back in dummy state");
  endtask

  task automatic report_test(input string name, input int errors_before);
    $display("Test %s: %s", name, (errors == errors_before) ? "passed" : "failed");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int base;
    rst_n         = 1'b0;
    entropy_ack   = 1'b0;
    entropy_data  = '0;
    rand_update   = 1'b0;
    rand_consumed = 1'b0;
    mode          = ModeNone;
    ready         = 1'b0;
    seed_update   = 1'b0;
    seed_data     = '0;
    refresh       = 1'b0;
    prescaler     = '0;
    limit         = '0;
    err_processed = 1'b0;
    lfsr_q        = 32'hc332_e7ed;
    checks        = 0;
    errors        = 0;
    $readmemh("bench/entropy_patterns.hex", patterns);
    apply_reset();

    // Dummy valid out of reset
    base = errors;
    check_bit(rand_early, 1'b1, "early after reset");
    check_bit(rand_valid, 1'b0, "valid at reset release");
    check_bit(entropy_req, 1'b0, "EDN request after reset");
    check_bit(err.valid, 1'b0, "error valid after reset");
    next_cycle();
    check_bit(rand_valid, 1'b1, "dummy valid");
    check_word(permute_word({32'd4, 32'd3, 32'd2, 32'd1}), "reset word");
    report_test("1 dummy valid", base);

    base = errors;
    mode  = ModeSw;
    ready = 1'b1;
    next_cycle();
    check_bit(rand_valid, 1'b0, "valid after ready");
    sw_reseed(0);
    finish_reseed(0, "SW seeded word");
    report_test("2 SW reseed", base);

    base = errors;
    consume_word();
    update_word();
    update_word();
    consume_word();
    report_test("3 consume and update", base);

    // Mode only changes through reset or the error path
    base = errors;
    apply_reset();
    mode  = ModeEdn;
    ready = 1'b1;
    next_cycle();
    edn_reseed(1);
    finish_reseed(1, "EDN seeded word");
    update_word();
    refresh = 1'b1;
    next_cycle();
    refresh = 1'b0;
    edn_reseed(2);
    finish_reseed(2, "EDN refresh word");
    consume_word();
    report_test("4 EDN reseed and refresh", base);

    // No ack so the timer runs out
    base = errors;
    limit     = 16'd3;
    prescaler = 10'd1;
    refresh   = 1'b1;
    next_cycle();
    refresh = 1'b0;
    wait_err("wait timer");
    check_err(ErrWaitTimerExpired, "wait timer error");
    check_bit(entropy_req, 1'b1, "EDN request at error");
    next_cycle();
    check_bit(err.valid, 1'b0, "error valid one cycle later");
    check_bit(entropy_req, 1'b1, "EDN request held after error");
    entropy_ack = 1'b1;
    next_cycle();
    entropy_ack = 1'b0;
    check_bit(entropy_req, 1'b0, "EDN request after late ack");
    clear_error();
    report_test("5 wait timer error", base);

    // Valid only drops here if the previous error was cleared
    base = errors;
    raise_ready(ModeNone);
    wait_err("mode");
    check_err(ErrIncorrectMode, "mode error");
    next_cycle();
    check_bit(err.valid, 1'b0, "error valid one cycle later");
    clear_error();
    raise_ready(ModeSw);
    report_test("6 invalid mode error", base);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(NumTests * CyclesPerTest * Period);
    $display("Watchdog ran out at %0t ns, the tests did not finish", $time);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== bench/entropy_patterns.hex ====
// Five words per test: four lane seeds (low 32 bits), then the first output word
// Tests in order: SW reseed, EDN reseed, EDN refresh reseed
0000000000000000000000000F0F0F0F
0000000000000000000000000F0F0F0F
0000000000000000000000000F0F0F0F
0000000000000000000000000F0F0F0F
A5A5A5A5A5A5A5A5A5A5A5A5A5A5A5A5
00000000000000000000000033333333
00000000000000000000000033333333
00000000000000000000000033333333
00000000000000000000000033333333
33333333333333333333333333333333
00000000000000000000000000000000
00000000000000000000000000000000
00000000000000000000000000000000
00000000000000000000000000000000
00000001000000010000000100000001

// ==== bench/tb_clock.sv ====
/*
 * Testbench clock source
 * Free-running clock, starts low
 */
`timescale 1ns/100ps

module tb_clock #(
  parameter int Period = 40
) (
  output logic clk_o
);

  initial clk_o = 1'b0;

  always #(Period / 2) clk_o = ~clk_o;

endmodule

// ==== entropy_gen.f ====
source/entropy_pkg.sv
source/entropy_ifs.sv
source/prng_lane.sv
source/seed_loader.sv
source/wait_timer.sv
source/rand_buffer.sv
source/entropy_fsm.sv
source/entropy_gen.sv
bench/tb_clock.sv
bench/entropy_gen_props.sv
bench/entropy_gen_tb.sv

// ==== source/entropy_fsm.sv ====
/*
 * Entropy control FSM
 * Latches the mode, runs SW or EDN reseeding, sequences word generation,
 * keeps the valid flag and reports wait-timer and mode errors
 */
`timescale 1ns/100ps

module entropy_fsm import entropy_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             entropy_ready_i,
  input  entropy_mode_e    mode_i,
  input  logic             seed_update_i,
  input  logic [LaneW-1:0] seed_data_i,
  input  logic [LaneW-1:0] entropy_data_i,
  input  logic             entropy_ack_i,
  output logic             entropy_req_o,
  input  logic             entropy_refresh_req_i,
  input  logic             err_processed_i,
  input  logic             rand_update_i,
  input  logic             rand_consumed_i,
  output logic             rand_valid_o,
  output logic             rand_early_o,
  output err_t             err_o,
  output logic             prng_en_o,
  output logic             data_update_o,
  seed_if.master           seed,
  timer_if.master          timer
);

  typedef enum logic [2:0] {
    StReset,
    StSwSeedWait,
    StEdn,
    StGenerate,
    StReady,
    StErrWaitExpired,
    StErrIncorrectMode,
    StErr
  } state_e;

  state_e        state_q, state_d;
  entropy_mode_e mode_q;
  logic          mode_latch;
  logic          valid_set, valid_clear;
  logic          entropy_req;
  logic          req_hold_q;
  // Consume path stays one extra cycle in Generate
  logic          gen_wait_set, gen_wait_q;

  ////////////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= StReset;
      mode_q     <= ModeNone;
      gen_wait_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      gen_wait_q <= gen_wait_set;
      if (mode_latch) begin
        mode_q <= mode_i;
      end
    end
  end

  // Set wins, the FSM only sets while other work goes on
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rand_valid_o <= 1'b0;
    end else if (valid_set) begin
      rand_valid_o <= 1'b1;
    end else if (valid_clear) begin
      rand_valid_o <= 1'b0;
    end
  end

  // Valid follows in the next cycle
  assign rand_early_o = valid_set;

  // EDN request is held until acknowledged, even if the FSM gave up on it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_hold_q <= 1'b0;
    end else begin
      req_hold_q <= (req_hold_q | entropy_req) & ~entropy_ack_i;
    end
  end

  assign entropy_req_o = entropy_req | req_hold_q;

  // Seed source follows the latched mode
  assign seed.word = (mode_q == ModeSw) ? seed_data_i : entropy_data_i;

  ////////////////////////////////////////////////////////////////////////////
  // Next state and outputs
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    mode_latch    = 1'b0;
    valid_set     = 1'b0;
    valid_clear   = 1'b0;
    entropy_req   = 1'b0;
    gen_wait_set  = 1'b0;
    prng_en_o     = 1'b0;
    data_update_o = 1'b0;
    seed.start    = 1'b0;
    seed.ack      = 1'b0;
    timer.update  = 1'b0;
    timer.enable  = 1'b0;
    err_o         = '0;

    unique case (state_q)
      StReset: begin
        if (entropy_ready_i) begin
          // Drop the dummy word and take the configured mode
          valid_clear = 1'b1;
          mode_latch  = 1'b1;
          if (mode_i == ModeSw) begin
            seed.start = 1'b1;
            state_d    = StSwSeedWait;
          end else if (mode_i == ModeEdn) begin
            seed.start   = 1'b1;
            timer.update = 1'b1;
            state_d      = StEdn;
          end else begin
            state_d = StErrIncorrectMode;
          end
        end else begin
          // Dummy valid so consumers can run before SW sets up
          valid_set = 1'b1;
        end
      end

      StSwSeedWait: begin
        // Each SW strobe acks one seed word
        seed.ack = seed_update_i;
        if (seed.done) begin
          prng_en_o     = 1'b1;
          data_update_o = 1'b1;
          valid_clear   = 1'b1;
          state_d       = StGenerate;
        end
      end

      StEdn: begin
        entropy_req  = seed.req;
        timer.enable = 1'b1;
        if (timer.expired) begin
          state_d = StErrWaitExpired;
        end else begin
          seed.ack = entropy_ack_i;
          if (seed.done) begin
            prng_en_o     = 1'b1;
            data_update_o = 1'b1;
            valid_clear   = 1'b1;
            state_d       = StGenerate;
          end else if (rand_update_i || rand_consumed_i) begin
            // Old word still used while the reseed is pending
            prng_en_o     = 1'b1;
            data_update_o = 1'b1;
            valid_clear   = rand_consumed_i;
          end
        end
      end

      StGenerate: begin
        if (!gen_wait_q) begin
          valid_set = 1'b1;
          state_d   = StReady;
        end
      end

      StReady: begin
        if (rand_update_i || rand_consumed_i) begin
          prng_en_o     = 1'b1;
          data_update_o = 1'b1;
          if (rand_consumed_i) begin
            valid_clear  = 1'b1;
            gen_wait_set = 1'b1;
            state_d      = StGenerate;
          end
        end else if (mode_q == ModeEdn && entropy_refresh_req_i) begin
          // Manual reseed from EDN
          seed.start   = 1'b1;
          timer.update = 1'b1;
          state_d      = StEdn;
        end
      end

      StErrWaitExpired: begin
        err_o.valid                  = 1'b1;
        err_o.code                   = ErrWaitTimerExpired;
        err_o.info.timer_view.count  = timer.value;
        state_d                      = StErr;
      end

      StErrIncorrectMode: begin
        err_o.valid                = 1'b1;
        err_o.code                 = ErrIncorrectMode;
        err_o.info.mode_view.mode  = mode_q;
        state_d                    = StErr;
      end

      StErr: begin
        // Keep valid so a running hash can finish
        valid_set     = 1'b1;
        prng_en_o     = rand_update_i | rand_consumed_i;
        data_update_o = rand_update_i | rand_consumed_i;
        if (err_processed_i) begin
          state_d = StReset;
        end
      end

      default: begin
        state_d = StReset;
      end
    endcase
  end

endmodule

// ==== source/entropy_gen.sv ====
/*
 * Entropy generator top level
 * Seeded PRNG for a masked hash core, fed by software or EDN
 */
`timescale 1ns/100ps

module entropy_gen import entropy_pkg::*; #(
  parameter int unsigned NumLanes = 4
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // EDN
  output logic                      entropy_req_o,
  input  logic                      entropy_ack_i,
  input  logic [LaneW-1:0]          entropy_data_i,
  // Randomness to the core
  output logic                      rand_valid_o,
  output logic                      rand_early_o,
  output logic [NumLanes*LaneW-1:0] rand_data_o,
  input  logic                      rand_update_i,
  input  logic                      rand_consumed_i,
  // Configuration
  input  entropy_mode_e             mode_i,
  input  logic                      entropy_ready_i,
  input  logic                      seed_update_i,
  input  logic [LaneW-1:0]          seed_data_i,
  input  logic                      entropy_refresh_req_i,
  input  logic [PrescalerW-1:0]     wait_timer_prescaler_i,
  input  logic [TimerW-1:0]         wait_timer_limit_i,
  // Errors
  output err_t                      err_o,
  input  logic                      err_processed_i
);

  seed_if  seed_bus ();
  timer_if timer_bus ();

  logic                      prng_en;
  logic                      data_update;
  logic [NumLanes-1:0]       lane_load;
  logic [LaneW-1:0]          lane_seed;
  logic [NumLanes*LaneW-1:0] lane_state;

  entropy_fsm u_fsm (
    .clk_i,
    .rst_ni,
    .entropy_ready_i,
    .mode_i,
    .seed_update_i,
    .seed_data_i,
    .entropy_data_i,
    .entropy_ack_i,
    .entropy_req_o,
    .entropy_refresh_req_i,
    .err_processed_i,
    .rand_update_i,
    .rand_consumed_i,
    .rand_valid_o,
    .rand_early_o,
    .err_o,
    .prng_en_o     (prng_en),
    .data_update_o (data_update),
    .seed          (seed_bus),
    .timer         (timer_bus)
  );

  wait_timer u_timer (
    .clk_i,
    .rst_ni,
    .wait_timer_prescaler_i,
    .wait_timer_limit_i,
    .timer (timer_bus)
  );

  seed_loader #(.NumLanes(NumLanes)) u_loader (
    .clk_i,
    .rst_ni,
    .seed        (seed_bus),
    .lane_load_o (lane_load),
    .lane_seed_o (lane_seed)
  );

  // Lane i starts from i + 1
  for (genvar i = 0; i < NumLanes; i++) begin : gen_lane
    prng_lane #(.LaneReset(LaneW'(i + 1))) u_lane (
      .clk_i,
      .rst_ni,
      .load_i  (lane_load[i]),
      .seed_i  (lane_seed),
      .step_i  (prng_en),
      .state_o (lane_state[i*LaneW +: LaneW])
    );
  end

  rand_buffer #(.NumLanes(NumLanes)) u_buffer (
    .clk_i,
    .rst_ni,
    .lane_state_i (lane_state),
    .update_i     (data_update),
    .rand_data_o
  );

endmodule

// ==== source/entropy_ifs.sv ====
/*
 * Internal links of the entropy generator
 * seed_if feeds seed words to the lanes, timer_if runs the EDN wait timer
 */
`timescale 1ns/100ps

// FSM to seed loader
interface seed_if import entropy_pkg::*; ();
  logic             start;
  logic             ack;
  logic [LaneW-1:0] word;
  logic             req;
  logic             done;

  modport master (output start, ack, word, input req, done);
  modport slave (input start, ack, word, output req, done);
endinterface

// FSM to EDN wait timer
interface timer_if import entropy_pkg::*; ();
  logic              update;
  logic              enable;
  logic              expired;
  logic [TimerW-1:0] value;

  modport master (output update, enable, input expired, value);
  modport slave (input update, enable, output expired, value);
endinterface

// ==== source/entropy_pkg.sv ====
/*
 * Entropy generator shared definitions
 * Widths, mode and error encodings and the error report type
 */
package entropy_pkg;

  // One lane, also the EDN bus and software seed width
  parameter int unsigned LaneW = 32;

  // EDN wait timer and its prescaler
  parameter int unsigned TimerW     = 16;
  parameter int unsigned PrescalerW = 10;

  // Odd stride of the output bit permutation
  parameter int unsigned PermStride = 37;

  // Substitute for an all-zero lane seed, an LFSR would lock up on zero
  parameter logic [LaneW-1:0] LaneFix = 32'h0000_0001;

  // Error info word width
  parameter int unsigned ErrInfoW = 24;

  typedef enum logic [1:0] {
    ModeNone = 2'd0,
    ModeSw   = 2'd1,
    ModeEdn  = 2'd2
  } entropy_mode_e;

  typedef enum logic [7:0] {
    ErrNone             = 8'd0,
    ErrWaitTimerExpired = 8'd1,
    ErrIncorrectMode    = 8'd2
  } err_code_e;

  // Info word, read by error code
  typedef union packed {
    // Remaining wait timer count
    struct packed {
      logic [ErrInfoW-TimerW-1:0] zero;
      logic [TimerW-1:0]          count;
    } timer_view;
    // Offending latched mode
    struct packed {
      logic [ErrInfoW-3:0] zero;
      entropy_mode_e       mode;
    } mode_view;
  } err_info_u;

  typedef struct packed {
    logic      valid;
    err_code_e code;
    err_info_u info;
  } err_t;

endpackage

// ==== source/prng_lane.sv ====
/*
 * PRNG lane
 * 32-bit Fibonacci LFSR, taps 32 22 2 1, seed load with zero fix
 */
`timescale 1ns/100ps

module prng_lane import entropy_pkg::*; #(
  parameter logic [LaneW-1:0] LaneReset = LaneFix
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             load_i,
  input  logic [LaneW-1:0] seed_i,
  input  logic             step_i,
  output logic [LaneW-1:0] state_o
);

  logic [LaneW-1:0] state_q;
  logic             feedback;

  assign feedback = state_q[31] ^ state_q[21] ^ state_q[1] ^ state_q[0];

  // Load beats step
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= LaneReset;
    end else if (load_i) begin
      state_q <= (seed_i == '0) ? LaneFix : seed_i;
    end else if (step_i) begin
      state_q <= {state_q[LaneW-2:0], feedback};
    end
  end

  assign state_o = state_q;

endmodule

// ==== source/rand_buffer.sv ====
/*
 * Random output buffer
 * Registers the permuted lane states, keeps PRNG glitches off the output
 */
`timescale 1ns/100ps

module rand_buffer import entropy_pkg::*; #(
  parameter int unsigned NumLanes = 4
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic [NumLanes*LaneW-1:0] lane_state_i,
  input  logic                      update_i,
  output logic [NumLanes*LaneW-1:0] rand_data_o
);

  localparam int unsigned DataW = NumLanes * LaneW;

  // Output bit i takes input bit (i * stride) mod width
  function automatic logic [DataW-1:0] permute(input logic [DataW-1:0] word);
    logic [DataW-1:0] res;
    for (int i = 0; i < DataW; i++) begin
      res[i] = word[(i * PermStride) % DataW];
    end
    return res;
  endfunction

  // Lane i resets to i + 1
  function automatic logic [DataW-1:0] lane_resets();
    logic [DataW-1:0] res;
    for (int l = 0; l < NumLanes; l++) begin
      res[l*LaneW +: LaneW] = LaneW'(l + 1);
    end
    return res;
  endfunction

  localparam logic [DataW-1:0] ResetWord = permute(lane_resets());

  // Captures lane states from before this edge's step
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rand_data_o <= ResetWord;
    end else if (update_i) begin
      rand_data_o <= permute(lane_state_i);
    end
  end

endmodule

// ==== source/seed_loader.sv ====
/*
 * Seed loader
 * Hands one acked seed word to each lane in turn and flags the end
 */
`timescale 1ns/100ps

module seed_loader import entropy_pkg::*; #(
  parameter int unsigned NumLanes = 4
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  seed_if.slave               seed,
  output logic [NumLanes-1:0] lane_load_o,
  output logic [LaneW-1:0]    lane_seed_o
);

  localparam int unsigned CntW = (NumLanes > 1) ? $clog2(NumLanes) : 1;

  logic [CntW-1:0] cnt_q;
  logic            req_q;
  logic            done_q;
  logic            write;
  logic            last;

  // Word taken while requesting
  assign write = req_q && seed.ack;
  assign last  = (cnt_q == CntW'(NumLanes - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q  <= '0;
      req_q  <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= write && last;
      if (seed.start) begin
        cnt_q <= '0;
        req_q <= 1'b1;
      end else if (write) begin
        cnt_q <= cnt_q + 1'b1;
        if (last) begin
          req_q <= 1'b0;
        end
      end
    end
  end

  // Strobe for the addressed lane only
  for (genvar i = 0; i < NumLanes; i++) begin : gen_load
    assign lane_load_o[i] = write && (cnt_q == CntW'(i));
  end

  assign lane_seed_o = seed.word;
  assign seed.req    = req_q;
  // Done once all lanes hold their new seed
  assign seed.done   = done_q;

endmodule

// ==== source/wait_timer.sv ====
/*
 * EDN wait timer
 * Prescaled down-counter, expires at zero if the limit was non-zero
 */
`timescale 1ns/100ps

module wait_timer import entropy_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [PrescalerW-1:0] wait_timer_prescaler_i,
  input  logic [TimerW-1:0]     wait_timer_limit_i,
  timer_if.slave                timer
);

  logic [PrescalerW-1:0] presc_reload_q, presc_cnt_q;
  logic [TimerW-1:0]     value_q;
  logic                  limit_nz_q;
  logic                  expired_q;
  logic                  tick;

  // One tick per prescaler wrap
  assign tick = timer.enable && (presc_cnt_q == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      presc_reload_q <= '0;
      presc_cnt_q    <= '0;
    end else if (timer.update) begin
      presc_reload_q <= wait_timer_prescaler_i;
      presc_cnt_q    <= wait_timer_prescaler_i;
    end else if (tick) begin
      presc_cnt_q <= presc_reload_q;
    end else if (timer.enable) begin
      presc_cnt_q <= presc_cnt_q - 1'b1;
    end
  end

  // Zero limit disables expiry
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      value_q    <= '0;
      limit_nz_q <= 1'b0;
      expired_q  <= 1'b0;
    end else if (timer.update) begin
      value_q    <= wait_timer_limit_i;
      limit_nz_q <= |wait_timer_limit_i;
      expired_q  <= 1'b0;
    end else if (timer.enable) begin
      if (tick && value_q != '0) begin
        value_q <= value_q - 1'b1;
      end
      if (value_q == '0 && limit_nz_q) begin
        expired_q <= 1'b1;
      end
    end
  end

  assign timer.expired = expired_q;
  assign timer.value   = value_q;

endmodule
